//--- flist.f
rtl/rename_pkg.sv
rtl/wb_pkg.sv
rtl/free_list.sv
rtl/rename_table.sv
rtl/reg_value_store.sv
rtl/rename_regfile_top.sv
testbench/tb_clock.sv
testbench/rename_regfile_assert.sv
testbench/rename_regfile_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rename_regfile_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/rename_regfile_tb.sv
// Directed tests against a model of map, free bitmap and values; avoids nested speculation
`default_nettype none
`timescale 1ns/10ps

module rename_regfile_tb
  import rename_pkg::*;
  import wb_pkg::*;
;

  localparam int DW = 32;
  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic rst;
  logic rn [RENAME_LANES];
  reg_idx_t rd [RENAME_LANES];
  reg_idx_t rs1 [RENAME_LANES];
  reg_idx_t rs2 [RENAME_LANES];
  logic spec [RENAME_LANES];
  wb_kind_t wk [WB_LANES];
  reg_idx_t warn [WB_LANES];
  reg_idx_t wrrn [WB_LANES];
  logic [DW-1:0] wres [WB_LANES];
  logic clr;
  logic del;
  reg_idx_t ridx [READ_PORTS];
  logic [DW-1:0] rdata [READ_PORTS];
  logic rvalid [READ_PORTS];
  reg_idx_t o_rn [RENAME_LANES];
  reg_idx_t o_rs1 [RENAME_LANES];
  reg_idx_t o_rs2 [RENAME_LANES];
  logic [1:0] cap;

  // Reference model state
  reg_idx_t m_map [32];
  logic m_tag [32];
  logic m_free [32];
  logic [DW-1:0] m_val [64];
  logic m_valid [64];
  logic m_rtag [32];

  reg_idx_t focus [2];
  logic [15:0] lfsr = 16'd40838;
  int window = 0;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int tests = 0;

  tb_clock #(.HALF_PERIOD(2)) u_clock (.o_clock(clk));

  rename_regfile_top #(.DATA_WIDTH(DW)) dut0 (
    .i_clock(clk), .i_reset(rst), .i_rename(rn), .i_rd(rd), .i_rs1(rs1), .i_rs2(rs2),
    .i_spec(spec), .i_wb_kind(wk), .i_wb_arn(warn), .i_wb_rrn(wrrn), .i_wb_result(wres),
    .i_clear_tag(clr), .i_delete_tag(del), .i_read_idx(ridx), .o_read_data(rdata),
    .o_read_valid(rvalid), .o_rn(o_rn), .o_rs1_map(o_rs1), .o_rs2_map(o_rs2),
    .o_rename_capacity(cap)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], b};
    return b;
  endfunction

  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // Lane l takes the l-th highest free rename register
  function automatic reg_idx_t model_alloc(int l);
    int seen;
    seen = 0;
    for (int k = 31; k >= 0; k--) begin
      if (m_free[k]) begin
        if (seen == l) begin
          return reg_idx_t'(32 + k);
        end
        seen++;
      end
    end
    return '0;
  endfunction

  function automatic int free_count();
    int n;
    n = 0;
    for (int k = 0; k < 32; k++) begin
      n += int'(m_free[k]);
    end
    return n;
  endfunction

  function automatic reg_idx_t xlate(reg_idx_t src);
    if (src < 32 && m_map[src[4:0]] != '0) begin
      return m_map[src[4:0]];
    end
    return src;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < 64; i++) begin
      m_val[i] = '0;
      m_valid[i] = (i < 32);
    end
    for (int i = 0; i < 32; i++) begin
      m_map[i] = '0;
      m_tag[i] = 1'b0;
      m_free[i] = 1'b1;
      m_rtag[i] = 1'b0;
    end
  endtask

  task automatic idle_inputs();
    for (int l = 0; l < 2; l++) begin
      rn[l] = 1'b0;
      rd[l] = '0;
      rs1[l] = '0;
      rs2[l] = '0;
      spec[l] = 1'b0;
      wk[l] = WB_NONE;
      warn[l] = '0;
      wrrn[l] = '0;
      wres[l] = '0;
      focus[l] = '0;
    end
    clr = 1'b0;
    del = 1'b0;
  endtask

  // Called 1 ns after an edge with inputs set; returns 1 ns after the next edge
  task automatic tick();
    reg_idx_t a [2];
    reg_idx_t e_rn [2];
    reg_idx_t e_rs1 [2];
    reg_idx_t e_rs2 [2];
    int n;
    for (int p = 0; p < 2; p++) begin
      ridx[p] = reg_idx_t'((window * 2 + p) % 64);
      ridx[p + 2] = focus[p];
    end
    window++;
    for (int l = 0; l < 2; l++) begin
      a[l] = model_alloc(l);
      e_rn[l] = rn[l] ? a[l] : '0;
      e_rs1[l] = xlate(rs1[l]);
      e_rs2[l] = xlate(rs2[l]);
    end
    #2;
    for (int p = 0; p < READ_PORTS; p++) begin
      check_val($sformatf("o_read_data[%0d] idx %0d", p, ridx[p]), rdata[p], m_val[ridx[p]]);
      check_val($sformatf("o_read_valid[%0d] idx %0d", p, ridx[p]),
                32'(rvalid[p]), 32'(m_valid[ridx[p]]));
    end
    // Model update in priority order
    if (clr) begin
      for (int i = 0; i < 32; i++) begin
        m_tag[i] = 1'b0;
        m_rtag[i] = 1'b0;
      end
    end
    if (del) begin
      for (int i = 0; i < 32; i++) begin
        if (m_tag[i]) begin
          m_map[i] = '0;
          m_tag[i] = 1'b0;
        end
        if (m_rtag[i]) begin
          m_val[32 + i] = '0;
          m_valid[32 + i] = 1'b0;
          m_rtag[i] = 1'b0;
          m_free[i] = 1'b1;
        end
      end
    end
    for (int w = 0; w < 2; w++) begin
      if (wk[w] == WB_EXEC && wrrn[w] >= 32) begin
        m_val[wrrn[w]] = wres[w];
        m_valid[wrrn[w]] = 1'b1;
      end else if (wk[w] == WB_COMMIT) begin
        if (warn[w] != 0 && warn[w] < 32) begin
          m_val[warn[w]] = wres[w];
          m_valid[warn[w]] = 1'b1;
          if (m_map[warn[w][4:0]] == wrrn[w]) begin
            m_map[warn[w][4:0]] = '0;
            m_tag[warn[w][4:0]] = 1'b0;
          end
        end
        if (wrrn[w] >= 32) begin
          m_val[wrrn[w]] = '0;
          m_valid[wrrn[w]] = 1'b0;
          m_rtag[wrrn[w][4:0]] = 1'b0;
          m_free[wrrn[w][4:0]] = 1'b1;
        end
      end
    end
    for (int l = 0; l < 2; l++) begin
      if (rn[l] && a[l] >= 32) begin
        m_valid[a[l]] = 1'b0;
        m_rtag[a[l][4:0]] = spec[l];
        m_free[a[l][4:0]] = 1'b0;
        if (rd[l] != 0 && rd[l] < 32) begin
          if (!spec[l]) begin
            m_valid[rd[l]] = 1'b0;
          end
          m_map[rd[l][4:0]] = a[l];
          m_tag[rd[l][4:0]] = spec[l];
        end
      end
    end
    n = free_count();
    @(posedge clk);
    #1;
    for (int l = 0; l < 2; l++) begin
      check_val($sformatf("o_rn[%0d]", l), 32'(o_rn[l]), 32'(e_rn[l]));
      check_val($sformatf("o_rs1_map[%0d]", l), 32'(o_rs1[l]), 32'(e_rs1[l]));
      check_val($sformatf("o_rs2_map[%0d]", l), 32'(o_rs2[l]), 32'(e_rs2[l]));
    end
    check_val("o_rename_capacity", 32'(cap), (n > 3) ? 32'd3 : 32'(n));
    idle_inputs();
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %s finished, %0d errors so far", name, errors);
  endtask

  task automatic test_reset();
    for (int i = 0; i < 20; i++) begin
      tick();
    end
    finish_test("reset");
  endtask

  task automatic test_dual_rename();
    rn[0] = 1'b1;
    rn[1] = 1'b1;
    rd[0] = 6'd5;
    rd[1] = 6'd6;
    tick();
    rs1[0] = 6'd5;
    rs2[0] = 6'd6;
    rs1[1] = 6'd6;
    focus[0] = 6'd5;
    focus[1] = 6'd6;
    tick();
    finish_test("dual_rename");
  endtask

  task automatic test_exec_commit();
    wk[0] = WB_EXEC;
    wrrn[0] = 6'd63;
    wres[0] = 32'h1234_5678;
    tick();
    focus[0] = 6'd63;
    wk[1] = WB_COMMIT;
    warn[1] = 6'd5;
    wrrn[1] = 6'd63;
    wres[1] = 32'h1234_5678;
    tick();
    focus[0] = 6'd5;
    rs1[0] = 6'd5;
    rn[0] = 1'b1;
    rd[0] = 6'd7;
    tick();
    rn[0] = 1'b1;
    rd[0] = 6'd6;
    tick();
    wk[0] = WB_COMMIT;
    warn[0] = 6'd6;
    wrrn[0] = 6'd62;
    wres[0] = 32'hcafe_0006;
    tick();
    rs1[0] = 6'd6;
    focus[0] = 6'd6;
    tick();
    finish_test("exec_commit");
  endtask

  task automatic test_clear_tag();
    reg_idx_t r8;
    reg_idx_t r9;
    for (int l = 0; l < 2; l++) begin
      rn[l] = 1'b1;
      spec[l] = 1'b1;
    end
    rd[0] = 6'd8;
    rd[1] = 6'd9;
    tick();
    r8 = m_map[8];
    r9 = m_map[9];
    clr = 1'b1;
    wk[0] = WB_EXEC;
    wrrn[0] = r8;
    wres[0] = 32'h0000_0808;
    focus[0] = 6'd8;
    tick();
    // Delete after clear must leave the former speculative state alone
    del = 1'b1;
    focus[0] = r8;
    tick();
    rs1[0] = 6'd8;
    rs2[0] = 6'd9;
    focus[0] = r8;
    wk[0] = WB_COMMIT;
    warn[0] = 6'd8;
    wrrn[0] = r8;
    wres[0] = 32'h8;
    wk[1] = WB_COMMIT;
    warn[1] = 6'd9;
    wrrn[1] = r9;
    wres[1] = 32'h9;
    tick();
    rs1[0] = 6'd8;
    rs2[0] = 6'd9;
    focus[0] = 6'd8;
    focus[1] = r8;
    tick();
    finish_test("clear_tag");
  endtask

  task automatic test_delete_tag();
    reg_idx_t r10;
    reg_idx_t r11;
    for (int l = 0; l < 2; l++) begin
      rn[l] = 1'b1;
      spec[l] = 1'b1;
    end
    rd[0] = 6'd10;
    rd[1] = 6'd11;
    tick();
    r10 = m_map[10];
    r11 = m_map[11];
    wk[0] = WB_EXEC;
    wrrn[0] = r10;
    wres[0] = 32'hdead_0010;
    tick();
    focus[0] = r10;
    del = 1'b1;
    tick();
    rs1[0] = 6'd10;
    rs2[0] = 6'd11;
    focus[0] = r10;
    focus[1] = r11;
    tick();
    rn[0] = 1'b1;
    rn[1] = 1'b1;
    rd[0] = 6'd12;
    rd[1] = 6'd13;
    tick();
    finish_test("delete_tag");
  endtask

  task automatic test_random_fill_drain();
    reg_idx_t q_arn [$];
    reg_idx_t q_rrn [$];
    int n;
    while (free_count() > 0) begin
      n = free_count();
      rn[0] = lfsr_bit();
      rn[1] = lfsr_bit();
      if (n == 1 || (!rn[0] && !rn[1])) begin
        rn[0] = 1'b1;
        rn[1] = (n > 1) ? rn[1] : 1'b0;
      end
      if (q_rrn.size() > 0) begin
        wk[0] = WB_EXEC;
        wrrn[0] = q_rrn[$];
        wres[0] = lfsr_bits(32);
      end
      for (int l = 0; l < 2; l++) begin
        rd[l] = reg_idx_t'(lfsr_bits(5));
        if (rd[l] == '0) begin
          rd[l] = 6'd1;
        end
        rs1[l] = reg_idx_t'(lfsr_bits(5));
        rs2[l] = reg_idx_t'(lfsr_bits(5));
        focus[l] = model_alloc(l);
        if (rn[l]) begin
          q_arn.push_back(rd[l]);
          q_rrn.push_back(model_alloc(l));
        end
      end
      tick();
    end
    while (q_rrn.size() > 0) begin
      for (int w = 0; w < 2; w++) begin
        if (q_rrn.size() > 0) begin
          wk[w] = WB_COMMIT;
          warn[w] = q_arn.pop_front();
          wrrn[w] = q_rrn.pop_front();
          wres[w] = lfsr_bits(32);
          focus[w] = warn[w];
        end
      end
      tick();
    end
    tick();
    finish_test("random_fill_drain");
  endtask

  initial begin
    rst = 1'b1;
    idle_inputs();
    for (int p = 0; p < READ_PORTS; p++) begin
      ridx[p] = '0;
    end
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_dual_rename();
    test_exec_commit();
    test_clear_tag();
    test_delete_tag();
    test_random_fill_drain();
    $display("Tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/rename_regfile_assert.sv
// Bound to rename_regfile_top, checks only while reset is low
`default_nettype none
`timescale 1ns/10ps

module rename_regfile_assert
  import rename_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input logic                  i_clock,
  input logic                  i_reset,
  input logic                  i_rename          [RENAME_LANES],
  input logic [1:0]            o_rename_capacity,
  input reg_idx_t              o_rn              [RENAME_LANES],
  input reg_idx_t              i_read_idx        [READ_PORTS],
  input logic [DATA_WIDTH-1:0] o_read_data       [READ_PORTS],
  input logic                  o_read_valid      [READ_PORTS]
);

  // Caller may not exceed the reported capacity
  assert property (@(posedge i_clock) disable iff (i_reset)
    ({1'b0, i_rename[0]} + {1'b0, i_rename[1]}) <= o_rename_capacity)
    else $error("more renames requested than the capacity allows");

  for (genvar l = 0; l < RENAME_LANES; l++) begin : g_lane
    assert property (@(posedge i_clock) disable iff (i_reset)
      !i_rename[l] |=> o_rn[l] == '0)
      else $error("idle rename lane %0d returned a nonzero o_rn", l);
  end

  // Entry 0 is a constant valid zero
  for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
    assert property (@(posedge i_clock) disable iff (i_reset)
      i_read_idx[p] == '0 |-> o_read_valid[p] && o_read_data[p] == '0)
      else $error("read port %0d of entry 0 is not a valid zero", p);
  end

endmodule

bind rename_regfile_top rename_regfile_assert #(
  .DATA_WIDTH (DATA_WIDTH)
) u_assert (
  .i_clock           (i_clock),
  .i_reset           (i_reset),
  .i_rename          (i_rename),
  .o_rename_capacity (o_rename_capacity),
  .o_rn              (o_rn),
  .i_read_idx        (i_read_idx),
  .o_read_data       (o_read_data),
  .o_read_valid      (o_read_valid)
);

`default_nettype wire

//--- testbench/tb_clock.sv
// Free-running clock with a fixed half period in ns, starts low at time zero
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD = 2
) (
  output logic o_clock
);

  initial begin
    o_clock = 1'b0;
  end

  always #(HALF_PERIOD) o_clock = ~o_clock;

endmodule

`default_nettype wire

//--- rtl/rename_regfile_top.sv
// Plain strobes with no back-pressure, renames per cycle must not exceed o_rename_capacity
`default_nettype none
`timescale 1ns/10ps

module rename_regfile_top
  import rename_pkg::*;
  import wb_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  i_clock,
  input  logic                  i_reset,
  // Rename request per lane
  input  logic                  i_rename          [RENAME_LANES],
  input  reg_idx_t              i_rd              [RENAME_LANES],
  input  reg_idx_t              i_rs1             [RENAME_LANES],
  input  reg_idx_t              i_rs2             [RENAME_LANES],
  input  logic                  i_spec            [RENAME_LANES],
  // Writeback lanes
  input  wb_kind_t              i_wb_kind         [WB_LANES],
  input  reg_idx_t              i_wb_arn          [WB_LANES],
  input  reg_idx_t              i_wb_rrn          [WB_LANES],
  input  logic [DATA_WIDTH-1:0] i_wb_result       [WB_LANES],
  // Speculation control
  input  logic                  i_clear_tag,
  input  logic                  i_delete_tag,
  // Value reads
  input  reg_idx_t              i_read_idx        [READ_PORTS],
  output logic [DATA_WIDTH-1:0] o_read_data       [READ_PORTS],
  output logic                  o_read_valid      [READ_PORTS],
  // Rename results, one cycle after the request
  output reg_idx_t              o_rn              [RENAME_LANES],
  output reg_idx_t              o_rs1_map         [RENAME_LANES],
  output reg_idx_t              o_rs2_map         [RENAME_LANES],
  output logic [1:0]            o_rename_capacity
);

  reg_idx_t               alloc_reg [RENAME_LANES];
  logic [RENAME_REGS-1:0] reclaim_mask;

  free_list u_free_list (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_rename          (i_rename),
    .o_alloc_reg       (alloc_reg),
    .i_wb_kind         (i_wb_kind),
    .i_wb_rrn          (i_wb_rrn),
    .i_reclaim_mask    (reclaim_mask),
    .o_rename_capacity (o_rename_capacity)
  );

  rename_table u_rename_table (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_rename     (i_rename),
    .i_rd         (i_rd),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_spec       (i_spec),
    .i_alloc_reg  (alloc_reg),
    .i_wb_kind    (i_wb_kind),
    .i_wb_arn     (i_wb_arn),
    .i_wb_rrn     (i_wb_rrn),
    .i_clear_tag  (i_clear_tag),
    .i_delete_tag (i_delete_tag),
    .o_rn         (o_rn),
    .o_rs1_map    (o_rs1_map),
    .o_rs2_map    (o_rs2_map)
  );

  reg_value_store #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_value_store (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_rename       (i_rename),
    .i_rd           (i_rd),
    .i_spec         (i_spec),
    .i_alloc_reg    (alloc_reg),
    .i_wb_kind      (i_wb_kind),
    .i_wb_arn       (i_wb_arn),
    .i_wb_rrn       (i_wb_rrn),
    .i_wb_result    (i_wb_result),
    .i_clear_tag    (i_clear_tag),
    .i_delete_tag   (i_delete_tag),
    .i_read_idx     (i_read_idx),
    .o_read_data    (o_read_data),
    .o_read_valid   (o_read_valid),
    .o_reclaim_mask (reclaim_mask)
  );

endmodule

`default_nettype wire

//--- rtl/reg_value_store.sv
// Architectural entries come out of reset valid and zero, entry 0 is never written
`default_nettype none
`timescale 1ns/10ps

module reg_value_store
  import rename_pkg::*;
  import wb_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_rename       [RENAME_LANES],
  input  reg_idx_t               i_rd           [RENAME_LANES],
  input  logic                   i_spec         [RENAME_LANES],
  input  reg_idx_t               i_alloc_reg    [RENAME_LANES],
  input  wb_kind_t               i_wb_kind      [WB_LANES],
  input  reg_idx_t               i_wb_arn       [WB_LANES],
  input  reg_idx_t               i_wb_rrn       [WB_LANES],
  input  logic [DATA_WIDTH-1:0]  i_wb_result    [WB_LANES],
  input  logic                   i_clear_tag,
  input  logic                   i_delete_tag,
  input  reg_idx_t               i_read_idx     [READ_PORTS],
  output logic [DATA_WIDTH-1:0]  o_read_data    [READ_PORTS],
  output logic                   o_read_valid   [READ_PORTS],
  output logic [RENAME_REGS-1:0] o_reclaim_mask
);

  localparam int ENTRIES = ARCH_REGS + RENAME_REGS;

  logic [DATA_WIDTH-1:0] value   [ENTRIES];
  logic                  valid   [ENTRIES];
  // Speculation tag, kept for the rename bank
  logic                  ren_tag [RENAME_REGS];

  // ----------------------------------------
  // Read ports and reclaim mask
  // ----------------------------------------
  always_comb begin
    for (int p = 0; p < READ_PORTS; p++) begin
      o_read_data[p]  = value[i_read_idx[p]];
      o_read_valid[p] = valid[i_read_idx[p]];
    end
  end

  // Tagged rename entries go back to the free list on delete
  always_comb begin
    for (int k = 0; k < RENAME_REGS; k++) begin
      o_reclaim_mask[k] = i_delete_tag && ren_tag[k];
    end
  end

  // ----------------------------------------
  // Entry update
  // ----------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int e = 0; e < ENTRIES; e++) begin
        value[e] <= '0;
        valid[e] <= (e < ARCH_REGS);
      end
      for (int k = 0; k < RENAME_REGS; k++) begin
        ren_tag[k] <= 1'b0;
      end
    end else begin
      if (i_clear_tag) begin
        for (int k = 0; k < RENAME_REGS; k++) begin
          ren_tag[k] <= 1'b0;
        end
      end

      if (i_delete_tag) begin
        for (int k = 0; k < RENAME_REGS; k++) begin
          if (ren_tag[k]) begin
            value[ARCH_REGS + k] <= '0;
            valid[ARCH_REGS + k] <= 1'b0;
            ren_tag[k]           <= 1'b0;
          end
        end
      end

      for (int w = 0; w < WB_LANES; w++) begin
        case (i_wb_kind[w])
          WB_EXEC: begin
            if (is_rename_reg(i_wb_rrn[w])) begin
              value[i_wb_rrn[w]] <= i_wb_result[w];
              valid[i_wb_rrn[w]] <= 1'b1;
            end
          end
          WB_COMMIT: begin
            if (is_writable_arch(i_wb_arn[w])) begin
              value[i_wb_arn[w]] <= i_wb_result[w];
              valid[i_wb_arn[w]] <= 1'b1;
            end
            // Retired rename entry returns to its reset state
            if (is_rename_reg(i_wb_rrn[w])) begin
              value[i_wb_rrn[w]]                <= '0;
              valid[i_wb_rrn[w]]                <= 1'b0;
              ren_tag[rename_slot(i_wb_rrn[w])] <= 1'b0;
            end
          end
          default: begin
          end
        endcase
      end

      // Renames last so they override a same-cycle commit
      for (int l = 0; l < RENAME_LANES; l++) begin
        if (i_rename[l] && is_rename_reg(i_alloc_reg[l])) begin
          valid[i_alloc_reg[l]]                <= 1'b0;
          ren_tag[rename_slot(i_alloc_reg[l])] <= i_spec[l];
          // Speculative rename keeps the architectural value usable
          if (!i_spec[l] && is_writable_arch(i_rd[l])) begin
            valid[i_rd[l]] <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rename_table.sv
// No intra-group source bypass and no nested speculation, rd 0 never gets a mapping
`default_nettype none
`timescale 1ns/10ps

module rename_table
  import rename_pkg::*;
  import wb_pkg::*;
(
  input  logic     i_clock,
  input  logic     i_reset,
  input  logic     i_rename     [RENAME_LANES],
  input  reg_idx_t i_rd         [RENAME_LANES],
  input  reg_idx_t i_rs1        [RENAME_LANES],
  input  reg_idx_t i_rs2        [RENAME_LANES],
  input  logic     i_spec       [RENAME_LANES],
  input  reg_idx_t i_alloc_reg  [RENAME_LANES],
  input  wb_kind_t i_wb_kind    [WB_LANES],
  input  reg_idx_t i_wb_arn     [WB_LANES],
  input  reg_idx_t i_wb_rrn     [WB_LANES],
  input  logic     i_clear_tag,
  input  logic     i_delete_tag,
  output reg_idx_t o_rn         [RENAME_LANES],
  output reg_idx_t o_rs1_map    [RENAME_LANES],
  output reg_idx_t o_rs2_map    [RENAME_LANES]
);

  // Zero in map_rrn means unmapped, rename indices are never below ARCH_REGS
  reg_idx_t map_rrn [ARCH_REGS];
  logic     map_tag [ARCH_REGS];

  // Source goes to its rename register when mapped, else stays architectural
  function automatic reg_idx_t translate(reg_idx_t src);
    reg_idx_t result;
    result = src;
    if (!is_rename_reg(src) && map_rrn[arn_idx_t'(src)] != '0) begin
      result = map_rrn[arn_idx_t'(src)];
    end
    return result;
  endfunction

  // ----------------------------------------
  // Registered rename results
  // ----------------------------------------
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int l = 0; l < RENAME_LANES; l++) begin
        o_rn[l]      <= '0;
        o_rs1_map[l] <= '0;
        o_rs2_map[l] <= '0;
      end
    end else begin
      for (int l = 0; l < RENAME_LANES; l++) begin
        o_rn[l]      <= i_rename[l] ? i_alloc_reg[l] : '0;
        o_rs1_map[l] <= translate(i_rs1[l]);
        o_rs2_map[l] <= translate(i_rs2[l]);
      end
    end
  end

  // ----------------------------------------
  // Map update
  // ----------------------------------------
  // Later statements win, so rename overrides commit and lane 1 overrides lane 0
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int a = 0; a < ARCH_REGS; a++) begin
        map_rrn[a] <= '0;
        map_tag[a] <= 1'b0;
      end
    end else begin
      // Branch resolved correctly, mappings become permanent
      if (i_clear_tag) begin
        for (int a = 0; a < ARCH_REGS; a++) begin
          map_tag[a] <= 1'b0;
        end
      end

      // Mispredict drops speculative mappings
      if (i_delete_tag) begin
        for (int a = 0; a < ARCH_REGS; a++) begin
          if (map_tag[a]) begin
            map_rrn[a] <= '0;
            map_tag[a] <= 1'b0;
          end
        end
      end

      // Commit unmaps only when the rrn is still the current mapping
      for (int w = 0; w < WB_LANES; w++) begin
        if (i_wb_kind[w] == WB_COMMIT && is_writable_arch(i_wb_arn[w])) begin
          if (map_rrn[arn_idx_t'(i_wb_arn[w])] == i_wb_rrn[w]) begin
            map_rrn[arn_idx_t'(i_wb_arn[w])] <= '0;
            map_tag[arn_idx_t'(i_wb_arn[w])] <= 1'b0;
          end
        end
      end

      for (int l = 0; l < RENAME_LANES; l++) begin
        if (i_rename[l] && is_writable_arch(i_rd[l])) begin
          map_rrn[arn_idx_t'(i_rd[l])] <= i_alloc_reg[l];
          map_tag[arn_idx_t'(i_rd[l])] <= i_spec[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
// Callers must stay within the reported capacity and release only rename registers in use
`default_nettype none
`timescale 1ns/10ps

module free_list
  import rename_pkg::*;
  import wb_pkg::*;
(
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_rename          [RENAME_LANES],
  output reg_idx_t               o_alloc_reg       [RENAME_LANES],
  input  wb_kind_t               i_wb_kind         [WB_LANES],
  input  reg_idx_t               i_wb_rrn          [WB_LANES],
  input  logic [RENAME_REGS-1:0] i_reclaim_mask,
  output logic [1:0]             o_rename_capacity
);

  localparam int CNT_W = $clog2(RENAME_REGS + 1);

  // One bit per rename register, set when free
  logic [RENAME_REGS-1:0] free_map;
  logic [RENAME_REGS-1:0] free_map_next;
  logic [CNT_W-1:0]       free_cnt;
  logic [CNT_W-1:0]       free_cnt_next;
  logic [CNT_W-1:0]       alloc_num;
  logic [CNT_W-1:0]       release_num;
  logic [CNT_W-1:0]       reclaim_num;
  logic                   found [RENAME_LANES];

  // ----------------------------------------
  // Priority pick
  // ----------------------------------------
  // Highest free slot to lane 0, next highest to lane 1 whether or not lane 0 renames
  always_comb begin
    logic [RENAME_REGS-1:0] avail;
    int                     slot;
    avail = free_map;
    for (int l = 0; l < RENAME_LANES; l++) begin
      found[l] = 1'b0;
      slot     = 0;
      for (int k = 0; k < RENAME_REGS; k++) begin
        if (avail[k]) begin
          found[l] = 1'b1;
          slot     = k;
        end
      end
      o_alloc_reg[l] = found[l] ? reg_idx_t'(ARCH_REGS + slot) : '0;
      if (found[l]) begin
        avail[slot] = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Bitmap and count update
  // ----------------------------------------
  always_comb begin
    free_map_next = free_map;
    alloc_num     = '0;
    release_num   = '0;
    reclaim_num   = '0;
    for (int l = 0; l < RENAME_LANES; l++) begin
      if (i_rename[l] && found[l]) begin
        free_map_next[rename_slot(o_alloc_reg[l])] = 1'b0;
        alloc_num = alloc_num + 1'b1;
      end
    end
    // Every commit returns its rrn, re-renamed or not
    for (int w = 0; w < WB_LANES; w++) begin
      if (i_wb_kind[w] == WB_COMMIT && is_rename_reg(i_wb_rrn[w])) begin
        free_map_next[rename_slot(i_wb_rrn[w])] = 1'b1;
        release_num = release_num + 1'b1;
      end
    end
    for (int k = 0; k < RENAME_REGS; k++) begin
      if (i_reclaim_mask[k]) begin
        reclaim_num = reclaim_num + 1'b1;
      end
    end
    free_map_next = free_map_next | i_reclaim_mask;
    free_cnt_next = free_cnt - alloc_num + release_num + reclaim_num;
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      free_map          <= '1;
      free_cnt          <= CNT_W'(RENAME_REGS);
      o_rename_capacity <= 2'(CAPACITY_MAX);
    end else begin
      free_map <= free_map_next;
      free_cnt <= free_cnt_next;
      // Capacity saturates at CAPACITY_MAX
      if (free_cnt_next > CNT_W'(CAPACITY_MAX)) begin
        o_rename_capacity <= 2'(CAPACITY_MAX);
      end else begin
        o_rename_capacity <= free_cnt_next[1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/wb_pkg.sv
// Writeback bus encoding, a lane carries at most one exec result or one commit per cycle
`default_nettype none

package wb_pkg;

  // Writeback lanes per cycle
  localparam int WB_LANES = 2;

  // ----------------------------------------
  // Writeback opcode
  // ----------------------------------------
  // WB_EXEC writes a rename register only
  // WB_COMMIT writes the architectural register and releases the rrn
  typedef enum logic [1:0] {
    WB_NONE   = 2'd0,
    WB_EXEC   = 2'd1,
    WB_COMMIT = 2'd2
  } wb_kind_t;

endpackage

`default_nettype wire

//--- rtl/rename_pkg.sv
// Index space of 32 architectural and 32 rename registers, only these sizes are supported
`default_nettype none

package rename_pkg;

  // ----------------------------------------
  // Index space
  // ----------------------------------------
  localparam int ARCH_REGS    = 32;
  localparam int RENAME_REGS  = 32;
  localparam int REG_IDX_W    = 6;
  localparam int ARN_W        = $clog2(ARCH_REGS);
  localparam int SLOT_W       = $clog2(RENAME_REGS);

  // Lanes and ports per cycle
  localparam int RENAME_LANES = 2;
  localparam int READ_PORTS   = 4;
  // Saturation of the reported rename capacity
  localparam int CAPACITY_MAX = 3;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [ARN_W-1:0]     arn_idx_t;
  typedef logic [SLOT_W-1:0]    slot_idx_t;

  // Rename registers sit above the architectural ones
  function automatic logic is_rename_reg(reg_idx_t idx);
    return idx >= reg_idx_t'(ARCH_REGS);
  endfunction

  // Architectural entry that may be written, entry 0 stays zero
  function automatic logic is_writable_arch(reg_idx_t idx);
    return (idx != '0) && !is_rename_reg(idx);
  endfunction

  // Position of a rename register inside the rename bank
  function automatic slot_idx_t rename_slot(reg_idx_t idx);
    return slot_idx_t'(idx - reg_idx_t'(ARCH_REGS));
  endfunction

endpackage

`default_nettype wire
